// File: core_shell.f
source/core_shell_pkg.sv
source/line_ram_2rw.sv
source/line_ram_1r1w.sv
source/dbus_decoder.sv
source/desc_mailbox.sv
source/data_port.sv
source/fetch_port.sv
source/core_shell.sv
dv/core_shell_tb.sv

// File: dv/core_shell_tb.sv
`timescale 1ns/1ps

module core_shell_tb;
  import core_shell_pkg::*;

  typedef enum logic [2:0] {
    op_dma_wr, op_dma_rd, op_ins_dma, op_core_rd,
    op_core_wr, op_fetch, op_desc_offer, op_desc_take
  } op_kind_t;

  typedef struct packed {
    op_kind_t    kind;
    logic [15:0] addr;
    logic [63:0] data;
    logic [1:0]  size;
    logic [63:0] exp;
  } op_t;

  localparam int max_wait    = 20;
  localparam int w_dbus_rsp  = 0;
  localparam int w_ibus_rsp  = 1;
  localparam int w_out_desc  = 2;
  localparam int w_in_taken  = 3;
  localparam int w_interrupt = 4;

  logic          clk;
  logic          rst;
  dbus_cmd_t     dbus_cmd;
  dbus_rsp_t     dbus_rsp;
  ibus_cmd_t     ibus_cmd;
  ibus_rsp_t     ibus_rsp;
  dma_data_req_t data_dma;
  logic [63:0]   data_dma_rd_data;
  ins_dma_req_t  ins_dma;
  logic [63:0]   in_desc;
  logic          in_desc_valid;
  logic          in_desc_taken;
  logic [63:0]   out_desc;
  logic          out_desc_valid;
  logic          out_desc_taken;
  core_msg_t     core_msg;
  logic          interrupt;

  op_t         ops[$];
  logic [63:0] dmem_model [4096];
  logic [63:0] imem_model [1024];
  logic [63:0] out_model;
  logic [31:0] lfsr_state;
  logic        dbus_err_exp;
  logic        ibus_err_exp;
  logic        out_lo_exp;
  logic        out_hi_exp;
  logic        in_lo_exp;
  logic        in_hi_exp;

  core_shell i_core_shell (
    .clk             (clk),
    .rst             (rst),
    .dbus_cmd        (dbus_cmd),
    .dbus_rsp        (dbus_rsp),
    .ibus_cmd        (ibus_cmd),
    .ibus_rsp        (ibus_rsp),
    .data_dma        (data_dma),
    .data_dma_rd_data(data_dma_rd_data),
    .ins_dma         (ins_dma),
    .in_desc         (in_desc),
    .in_desc_valid   (in_desc_valid),
    .in_desc_taken   (in_desc_taken),
    .out_desc        (out_desc),
    .out_desc_valid  (out_desc_valid),
    .out_desc_taken  (out_desc_taken),
    .core_msg        (core_msg),
    .interrupt       (interrupt)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////////////////////////
  // Reference rules
  ////////////////////////////////////////

  // Fibonacci LFSR x^32 + x^22 + x^2 + x + 1 stepped once per bit
  function automatic logic [31:0] rand_word();
    logic [31:0] w;
    logic        fb;
    w = '0;
    for (int i = 0; i < 32; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      w = {w[30:0], fb};
    end
    return w;
  endfunction

  function automatic logic [3:0] lanes(logic [15:0] addr, logic [1:0] size);
    case (size)
      size_byte: return 4'b0001 << addr[1:0];
      size_half: return 4'b0011 << addr[1:0];
      default:   return 4'b1111;
    endcase
  endfunction

  // Bytes of the word land in the half of the line picked by addr[2]
  function automatic logic [63:0] merge_word(logic [63:0] line, logic [15:0] addr,
                                             logic [31:0] data, logic [3:0] mask);
    logic [63:0] res;
    int          base;
    res  = line;
    base = addr[2] ? 32 : 0;
    for (int i = 0; i < 4; i++) begin
      if (mask[i]) begin
        res[base + i*8 +: 8] = data[i*8 +: 8];
      end
    end
    return res;
  endfunction

  function automatic core_msg_t expected_msg(logic [15:0] addr, logic [31:0] data,
                                             logic [1:0] size);
    core_msg_t m;
    m.valid = (addr >= coherent_start) && (addr < 16'h8000);
    m.addr  = addr[14:0];
    m.strb  = lanes(addr, size);
    m.data  = data;
    return m;
  endfunction

  function automatic logic [63:0] model_word(logic [15:0] addr);
    logic [63:0] line;
    line = dmem_model[addr[14:3]];
    return addr[2] ? {32'h0, line[63:32]} : {32'h0, line[31:0]};
  endfunction

  ////////////////////////////////////////
  // Operation table
  ////////////////////////////////////////

  function automatic op_t make_op(op_kind_t kind, logic [15:0] addr, logic [63:0] data,
                                  logic [1:0] size, logic [63:0] exp);
    op_t op;
    op.kind = kind;
    op.addr = addr;
    op.data = data;
    op.size = size;
    op.exp  = exp;
    return op;
  endfunction

  function automatic void push_op(op_kind_t kind, logic [15:0] addr, logic [63:0] data,
                                  logic [1:0] size, logic [63:0] exp);
    ops.push_back(make_op(kind, addr, data, size, exp));
  endfunction

  function automatic void dma_line(logic [15:0] addr);
    logic [63:0] line;
    line = {rand_word(), rand_word()};
    dmem_model[addr[14:3]] = line;
    push_op(op_dma_wr, addr, line, 2'd3, 64'h0);
  endfunction

  function automatic void ins_line(logic [15:0] addr);
    logic [63:0] line;
    line = {rand_word(), rand_word()};
    imem_model[addr[12:3]] = line;
    push_op(op_ins_dma, addr, line, 2'd3, 64'h0);
  endfunction

  function automatic void core_write(logic [15:0] addr, logic [1:0] size);
    logic [31:0] word;
    word = rand_word();
    if (addr[15]) begin
      out_model = merge_word(out_model, addr, word, lanes(addr, size));
    end else begin
      dmem_model[addr[14:3]] = merge_word(dmem_model[addr[14:3]], addr, word,
                                          lanes(addr, size));
    end
    push_op(op_core_wr, addr, {32'h0, word}, size, 64'h0);
  endfunction

  function automatic void fetch(logic [15:0] addr);
    logic [63:0] line;
    line = imem_model[addr[12:3]];
    push_op(op_fetch, addr, 64'h0, 2'd2, addr[2] ? {32'h0, line[63:32]} : {32'h0, line[31:0]});
  endfunction

  function automatic void build_table();
    logic [63:0] desc;
    dma_line(16'h0100);
    dma_line(16'h0108);
    dma_line(16'h6ff8);
    dma_line(16'h7000);
    dma_line(16'h7ff0);
    push_op(op_core_rd, 16'h0100, 64'h0, 2'd2, model_word(16'h0100));
    push_op(op_core_rd, 16'h0104, 64'h0, 2'd2, model_word(16'h0104));
    push_op(op_core_rd, 16'h010c, 64'h0, 2'd2, model_word(16'h010c));
    core_write(16'h0101, size_byte);
    core_write(16'h0106, size_half);
    core_write(16'h0108, 2'd2);
    // Around the coherent start
    core_write(16'h6ffc, 2'd2);
    core_write(16'h6fff, size_byte);
    core_write(16'h7004, 2'd2);
    core_write(16'h7ff2, size_half);
    core_write(16'h7ff5, size_byte);
    push_op(op_dma_rd, 16'h0100, 64'h0, 2'd3, dmem_model[12'h020]);
    push_op(op_dma_rd, 16'h0108, 64'h0, 2'd3, dmem_model[12'h021]);
    push_op(op_dma_rd, 16'h6ff8, 64'h0, 2'd3, dmem_model[12'hdff]);
    push_op(op_dma_rd, 16'h7000, 64'h0, 2'd3, dmem_model[12'he00]);
    push_op(op_dma_rd, 16'h7ff0, 64'h0, 2'd3, dmem_model[12'hffe]);
    push_op(op_core_rd, 16'h7ff4, 64'h0, 2'd2, model_word(16'h7ff4));
    // Outgoing descriptor with the high half patched after valid
    core_write(16'h8008, 2'd2);
    core_write(16'h800c, 2'd2);
    core_write(16'h800d, size_byte);
    push_op(op_desc_take, 16'h0, 64'h0, 2'd0, out_model);
    // Incoming descriptor and then a read with nothing offered
    desc = {rand_word(), rand_word()};
    push_op(op_desc_offer, 16'h0, desc, 2'd1, 64'h0);
    push_op(op_core_rd, 16'h8000, 64'h0, 2'd2, {32'h0, desc[31:0]});
    push_op(op_core_rd, 16'h8004, 64'h0, 2'd2, {32'h0, desc[63:32]});
    push_op(op_desc_offer, 16'h0, 64'h0, 2'd0, 64'h0);
    push_op(op_core_rd, 16'h8004, 64'h0, 2'd2, 64'h0);
    // Instruction store
    ins_line(16'h0000);
    ins_line(16'h0008);
    ins_line(16'h1ff8);
    fetch(16'h0000);
    fetch(16'h0004);
    fetch(16'h000c);
    fetch(16'h1ffc);
    fetch(16'h1ff8);
  endfunction

  ////////////////////////////////////////
  // Checks and waits
  ////////////////////////////////////////

  task automatic stop_run(string line);
    $display("%s", line);
    $display("STATUS: FAIL");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic check_dbus(dbus_rsp_t got, dbus_rsp_t exp, logic with_data, string what);
    if (got.valid !== exp.valid || got.error !== exp.error ||
        (with_data && got.data !== exp.data)) begin
      stop_run($sformatf("[FAIL] t=%0t %s: got v=%b e=%b d=%h, expected v=%b e=%b d=%h",
                         $time, what, got.valid, got.error, got.data,
                         exp.valid, exp.error, exp.data));
    end
  endtask

  task automatic check_ibus(ibus_rsp_t got, ibus_rsp_t exp, logic with_inst, string what);
    if (got.valid !== exp.valid || got.error !== exp.error ||
        (with_inst && got.inst !== exp.inst)) begin
      stop_run($sformatf("[FAIL] t=%0t %s: got v=%b e=%b i=%h, expected v=%b e=%b i=%h",
                         $time, what, got.valid, got.error, got.inst,
                         exp.valid, exp.error, exp.inst));
    end
  endtask

  // Other fields only matter when a message is expected
  task automatic check_msg(core_msg_t got, core_msg_t exp, string what);
    if (got.valid !== exp.valid || (exp.valid && got !== exp)) begin
      stop_run($sformatf("[FAIL] t=%0t %s: got msg %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_line(logic [63:0] got, logic [63:0] exp, string what);
    if (got !== exp) begin
      stop_run($sformatf("[FAIL] t=%0t %s: got %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_flag(logic got, logic exp, string what);
    if (got !== exp) begin
      stop_run($sformatf("[FAIL] t=%0t %s: got %b, expected %b", $time, what, got, exp));
    end
  endtask

  function automatic logic event_seen(int which);
    case (which)
      w_dbus_rsp: return dbus_rsp.valid;
      w_ibus_rsp: return ibus_rsp.valid;
      w_out_desc: return out_desc_valid;
      w_in_taken: return in_desc_taken;
      default:    return interrupt;
    endcase
  endfunction

  task automatic wait_for(int which, string what);
    int n;
    n = 0;
    while (event_seen(which) !== 1'b1) begin
      if (n == max_wait) begin
        stop_run($sformatf("Timeout: %s did not arrive within %0d cycles", what, max_wait));
      end
      @(posedge clk);
      #1;
      n++;
    end
  endtask

  ////////////////////////////////////////
  // Drivers
  ////////////////////////////////////////

  task automatic drive_core(op_t op, logic with_data);
    dbus_rsp_t exp;
    logic      in_win;
    in_win           = (op.addr[15:4] == 12'h800);
    dbus_cmd.valid   = 1'b1;
    dbus_cmd.wr      = (op.kind == op_core_wr);
    dbus_cmd.address = op.addr;
    dbus_cmd.data    = op.data[31:0];
    dbus_cmd.size    = op.size;
    if (op.kind == op_core_wr) begin
      #1;
      check_msg(core_msg, expected_msg(op.addr, op.data[31:0], op.size),
                $sformatf("message for write at %h", op.addr));
    end
    @(posedge clk);
    #1;
    dbus_cmd = '0;
    wait_for(w_dbus_rsp, "data bus response");
    exp.valid = 1'b1;
    exp.error = dbus_err_exp;
    exp.data  = op.exp[31:0];
    check_dbus(dbus_rsp, exp, with_data, $sformatf("core access at %h", op.addr));
    // Outgoing valid needs both halves written
    if (in_win && op.kind == op_core_wr && op.addr[3]) begin
      if (op.addr[2]) begin
        out_hi_exp = 1'b1;
      end else begin
        out_lo_exp = 1'b1;
      end
      check_flag(out_desc_valid, out_lo_exp && out_hi_exp,
                 $sformatf("out_desc_valid after write at %h", op.addr));
    end
    // Incoming taken needs both halves read while offered
    if (in_win && op.kind == op_core_rd && !op.addr[3]) begin
      if (!in_desc_valid) begin
        in_lo_exp = 1'b0;
        in_hi_exp = 1'b0;
      end else if (op.addr[2]) begin
        in_hi_exp = 1'b1;
      end else begin
        in_lo_exp = 1'b1;
      end
      check_flag(in_desc_taken, in_lo_exp && in_hi_exp,
                 $sformatf("in_desc_taken after read at %h", op.addr));
    end
  endtask

  task automatic fetch_word(logic [15:0] pc, logic [31:0] inst, logic with_inst);
    ibus_rsp_t exp;
    ibus_cmd.valid = 1'b1;
    ibus_cmd.pc    = {16'h0, pc};
    @(posedge clk);
    #1;
    ibus_cmd = '0;
    wait_for(w_ibus_rsp, "fetch response");
    exp.valid = 1'b1;
    exp.error = ibus_err_exp;
    exp.inst  = inst;
    check_ibus(ibus_rsp, exp, with_inst, $sformatf("fetch at %h", pc));
  endtask

  task automatic take_out_desc(logic [63:0] exp);
    wait_for(w_out_desc, "out_desc_valid");
    check_line(out_desc, exp, "outgoing descriptor");
    // Held while the queue is not taking
    repeat (3) begin
      @(posedge clk);
      #1;
      check_flag(out_desc_valid, 1'b1, "out_desc_valid under back-pressure");
      check_line(out_desc, exp, "held descriptor");
    end
    out_desc_taken = 1'b1;
    @(posedge clk);
    #1;
    out_desc_taken = 1'b0;
    check_flag(out_desc_valid, 1'b0, "out_desc_valid after taken");
    out_lo_exp = 1'b0;
    out_hi_exp = 1'b0;
  endtask

  task automatic apply_op(op_t op);
    case (op.kind)
      op_dma_wr, op_dma_rd: begin
        data_dma.en      = 1'b1;
        data_dma.ren     = (op.kind == op_dma_rd);
        data_dma.wen     = (op.kind == op_dma_wr) ? 8'hff : 8'h00;
        data_dma.addr    = op.addr;
        data_dma.wr_data = op.data;
        @(posedge clk);
        #1;
        data_dma = '0;
        if (op.kind == op_dma_rd) begin
          check_line(data_dma_rd_data, op.exp, $sformatf("DMA read at %h", op.addr));
        end
      end
      op_ins_dma: begin
        ins_dma.wen     = 8'hff;
        ins_dma.addr    = op.addr;
        ins_dma.wr_data = op.data;
        @(posedge clk);
        #1;
        ins_dma = '0;
      end
      op_core_rd, op_core_wr: drive_core(op, op.kind == op_core_rd);
      op_fetch: fetch_word(op.addr, op.exp[31:0], 1'b1);
      op_desc_offer: begin
        if (op.size != 2'd0) begin
          in_desc       = op.data;
          in_desc_valid = 1'b1;
        end else begin
          wait_for(w_in_taken, "in_desc_taken");
          @(posedge clk);
          #1;
          in_desc_valid = 1'b0;
          check_flag(in_desc_taken, 1'b0, "in_desc_taken after handshake");
          in_lo_exp = 1'b0;
          in_hi_exp = 1'b0;
        end
      end
      default: take_out_desc(op.exp);
    endcase
  endtask

  task automatic run_error_checks();
    check_flag(interrupt, 1'b0, "interrupt before bound errors");
    // Fetch past the instruction store sets the sticky error
    ibus_err_exp = 1'b1;
    fetch_word(16'h2000, 32'h0, 1'b0);
    apply_op(make_op(op_fetch, 16'h0004, 64'h0, 2'd2, {32'h0, imem_model[0][63:32]}));
    // Read from the write half of the descriptor window
    dbus_err_exp = 1'b1;
    drive_core(make_op(op_core_rd, 16'h8008, 64'h0, 2'd2, 64'h0), 1'b0);
    drive_core(make_op(op_core_rd, 16'h0104, 64'h0, 2'd2, model_word(16'h0104)), 1'b1);
    // DMA read above the data memory
    data_dma.en   = 1'b1;
    data_dma.ren  = 1'b1;
    data_dma.addr = 16'h8000;
    @(posedge clk);
    #1;
    data_dma = '0;
    // Response strobes last one cycle only
    check_flag(dbus_rsp.valid, 1'b0, "dbus_rsp.valid with no command");
    check_flag(ibus_rsp.valid, 1'b0, "ibus_rsp.valid with no command");
    wait_for(w_interrupt, "interrupt");
    repeat (4) begin
      @(posedge clk);
      #1;
      check_flag(interrupt, 1'b1, "sticky interrupt");
    end
  endtask

  initial begin
    rst            = 1'b1;
    dbus_cmd       = '0;
    ibus_cmd       = '0;
    data_dma       = '0;
    ins_dma        = '0;
    in_desc        = '0;
    in_desc_valid  = 1'b0;
    out_desc_taken = 1'b0;
    lfsr_state     = 32'he251;
    out_model      = '0;
    dbus_err_exp   = 1'b0;
    ibus_err_exp   = 1'b0;
    out_lo_exp     = 1'b0;
    out_hi_exp     = 1'b0;
    in_lo_exp      = 1'b0;
    in_hi_exp      = 1'b0;
    build_table();
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    check_flag(dbus_rsp.valid, 1'b0, "dbus_rsp.valid after reset");
    check_flag(ibus_rsp.valid, 1'b0, "ibus_rsp.valid after reset");
    check_flag(out_desc_valid, 1'b0, "out_desc_valid after reset");
    check_flag(in_desc_taken, 1'b0, "in_desc_taken after reset");
    foreach (ops[i]) begin
      apply_op(ops[i]);
    end
    run_error_checks();
    $display("STATUS: PASS");
    $finish;
  end

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/1ps -j 0 \
  --top-module core_shell_tb \
  -f core_shell.f \
  -o core_shell_sim
./obj_dir/core_shell_sim

// File: source/core_shell.sv
`timescale 1ns/1ps

module core_shell (
  input  logic                                clk,
  input  logic                                rst,
  input  core_shell_pkg::dbus_cmd_t           dbus_cmd,
  output core_shell_pkg::dbus_rsp_t           dbus_rsp,
  input  core_shell_pkg::ibus_cmd_t           ibus_cmd,
  output core_shell_pkg::ibus_rsp_t           ibus_rsp,
  input  core_shell_pkg::dma_data_req_t       data_dma,
  output logic [core_shell_pkg::line_bits-1:0] data_dma_rd_data,
  input  core_shell_pkg::ins_dma_req_t        ins_dma,
  input  logic [core_shell_pkg::line_bits-1:0] in_desc,
  input  logic                                in_desc_valid,
  output logic                                in_desc_taken,
  output logic [core_shell_pkg::line_bits-1:0] out_desc,
  output logic                                out_desc_valid,
  input  logic                                out_desc_taken,
  output core_shell_pkg::core_msg_t           core_msg,
  output logic                                interrupt
);
  import core_shell_pkg::*;

  mem_req_t    mem_req;
  desc_req_t   desc_req;
  logic        rsp_valid;
  logic        rsp_error;
  logic [31:0] desc_rd_data;
  logic        desc_rd_sel;
  logic        out_of_bound;

  ////////////////////////////////////////
  // Data bus path
  ////////////////////////////////////////

  dbus_decoder i_dbus_decoder (
    .clk      (clk),
    .rst      (rst),
    .cmd      (dbus_cmd),
    .mem_req  (mem_req),
    .desc_req (desc_req),
    .msg      (core_msg),
    .rsp_valid(rsp_valid),
    .rsp_error(rsp_error)
  );

  desc_mailbox i_desc_mailbox (
    .clk           (clk),
    .rst           (rst),
    .req           (desc_req),
    .in_desc       (in_desc),
    .in_desc_valid (in_desc_valid),
    .in_desc_taken (in_desc_taken),
    .out_desc      (out_desc),
    .out_desc_valid(out_desc_valid),
    .out_desc_taken(out_desc_taken),
    .rd_data       (desc_rd_data),
    .rd_sel        (desc_rd_sel)
  );

  data_port i_data_port (
    .clk         (clk),
    .mem_req     (mem_req),
    .rsp_valid   (rsp_valid),
    .rsp_error   (rsp_error),
    .desc_rd_data(desc_rd_data),
    .desc_rd_sel (desc_rd_sel),
    .rsp         (dbus_rsp),
    .dma         (data_dma),
    .dma_rd_data (data_dma_rd_data)
  );

  fetch_port i_fetch_port (
    .clk(clk),
    .rst(rst),
    .cmd(ibus_cmd),
    .rsp(ibus_rsp),
    .dma(ins_dma)
  );

  ////////////////////////////////////////
  // DMA bound check
  ////////////////////////////////////////

  assign out_of_bound =
    (data_dma.en && |data_dma.addr[addr_bits-1:dmem_addr_bits]) ||
    (|ins_dma.wen && |ins_dma.addr[addr_bits-1:imem_addr_bits]);

  // Held until reset
  always_ff @(posedge clk) begin
    if (rst) begin
      interrupt <= 1'b0;
    end else begin
      interrupt <= interrupt || out_of_bound;
    end
  end

endmodule

// File: source/core_shell_pkg.sv
package core_shell_pkg;

  // Memory line and address geometry
  localparam int line_bytes     = 8;
  localparam int line_bits      = 64;
  localparam int line_off_bits  = $clog2(line_bytes);
  localparam int addr_bits      = 16;
  localparam int dmem_addr_bits = 15;
  localparam int imem_addr_bits = 13;
  localparam int dmem_line_bits = dmem_addr_bits - line_off_bits;
  localparam int imem_line_bits = imem_addr_bits - line_off_bits;

  // Address map
  localparam logic [addr_bits-1:0] coherent_start = 16'h6fff;
  localparam logic [addr_bits-1:0] io_limit       = 16'h8000 + 16'd16;

  // Core access sizes, anything else is a full word
  localparam logic [1:0] size_byte = 2'd0;
  localparam logic [1:0] size_half = 2'd1;

  typedef struct packed {
    logic                 valid;
    logic                 wr;
    logic [addr_bits-1:0] address;
    logic [31:0]          data;
    logic [1:0]           size;
  } dbus_cmd_t;

  typedef struct packed {
    logic        valid;
    logic        error;
    logic [31:0] data;
  } dbus_rsp_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
  } ibus_cmd_t;

  typedef struct packed {
    logic        valid;
    logic        error;
    logic [31:0] inst;
  } ibus_rsp_t;

  typedef struct packed {
    logic                  en;
    logic                  ren;
    logic [line_bytes-1:0] wen;
    logic [addr_bits-1:0]  addr;
    logic [line_bits-1:0]  wr_data;
  } dma_data_req_t;

  typedef struct packed {
    logic [line_bytes-1:0] wen;
    logic [addr_bits-1:0]  addr;
    logic [line_bits-1:0]  wr_data;
  } ins_dma_req_t;

  typedef struct packed {
    logic                      valid;
    logic [dmem_addr_bits-1:0] addr;
    logic [3:0]                strb;
    logic [31:0]               data;
  } core_msg_t;

  typedef struct packed {
    logic                      en;
    logic [dmem_line_bits-1:0] line;
    logic [line_bytes-1:0]     wen;
    logic [line_bits-1:0]      wr_data;
    logic                      word_sel;
  } mem_req_t;

  typedef struct packed {
    logic        wen;
    logic        ren;
    logic        high;
    logic [3:0]  mask;
    logic [31:0] wr_data;
  } desc_req_t;

  // Data address as seen by the memory and by the descriptor window
  typedef struct packed {
    logic                      io;
    logic [dmem_line_bits-1:0] line;
    logic                      word_sel;
    logic [1:0]                byte_off;
  } dbus_mem_addr_t;

  typedef struct packed {
    logic        io;
    logic [10:0] unused;
    logic        wr_win;
    logic        high;
    logic [1:0]  byte_off;
  } dbus_io_addr_t;

  typedef union packed {
    dbus_mem_addr_t mem;
    dbus_io_addr_t  io;
  } dbus_addr_u;

endpackage

// File: source/data_port.sv
`timescale 1ns/1ps

module data_port (
  input  logic                                clk,
  input  core_shell_pkg::mem_req_t            mem_req,
  input  logic                                rsp_valid,
  input  logic                                rsp_error,
  input  logic [31:0]                         desc_rd_data,
  input  logic                                desc_rd_sel,
  output core_shell_pkg::dbus_rsp_t           rsp,
  input  core_shell_pkg::dma_data_req_t       dma,
  output logic [core_shell_pkg::line_bits-1:0] dma_rd_data
);
  import core_shell_pkg::*;

  logic                 word_sel_q;
  logic [line_bits-1:0] core_line;
  logic                 core_ren;

  // Lines with no byte lane set are reads
  assign core_ren = ~|mem_req.wen;

  line_ram_2rw #(
    .depth_bits(dmem_line_bits)
  ) i_dmem (
    .clk  (clk),
    .ena  (mem_req.en),
    .rena (core_ren),
    .wena (mem_req.wen),
    .addra(mem_req.line),
    .dina (mem_req.wr_data),
    .douta(core_line),
    .enb  (dma.en),
    .renb (dma.ren),
    .wenb (dma.wen),
    .addrb(dma.addr[dmem_addr_bits-1:line_off_bits]),
    .dinb (dma.wr_data),
    .doutb(dma_rd_data)
  );

  // Half select follows the read data through the RAM stage
  always_ff @(posedge clk) begin
    word_sel_q <= mem_req.word_sel;
  end

  // Response word from the mailbox or the selected half of the line
  always_comb begin
    rsp.valid = rsp_valid;
    rsp.error = rsp_error;
    if (desc_rd_sel) begin
      rsp.data = desc_rd_data;
    end else if (word_sel_q) begin
      rsp.data = core_line[63:32];
    end else begin
      rsp.data = core_line[31:0];
    end
  end

endmodule

// File: source/dbus_decoder.sv
`timescale 1ns/1ps

module dbus_decoder (
  input  logic                      clk,
  input  logic                      rst,
  input  core_shell_pkg::dbus_cmd_t cmd,
  output core_shell_pkg::mem_req_t  mem_req,
  output core_shell_pkg::desc_req_t desc_req,
  output core_shell_pkg::core_msg_t msg,
  output logic                      rsp_valid,
  output logic                      rsp_error
);
  import core_shell_pkg::*;

  dbus_addr_u addr;
  logic [3:0] word_mask;
  logic       is_write;
  logic       in_window;
  logic       bad_access;

  assign addr     = cmd.address;
  assign is_write = cmd.valid && cmd.wr;

  // Byte lanes inside the 32-bit word, empty for reads and idle cycles
  always_comb begin
    word_mask = 4'h0;
    if (is_write) begin
      case (cmd.size)
        size_byte: word_mask = 4'b0001 << addr.mem.byte_off;
        size_half: word_mask = 4'b0011 << addr.mem.byte_off;
        default:   word_mask = 4'b1111;
      endcase
    end
  end

  ////////////////////////////////////////
  // Data memory region
  ////////////////////////////////////////

  always_comb begin
    mem_req.en       = cmd.valid && !addr.mem.io;
    mem_req.line     = addr.mem.line;
    mem_req.word_sel = addr.mem.word_sel;
    // Move word and lanes into the selected half of the line
    mem_req.wen      = {4'h0, word_mask} << {addr.mem.word_sel, 2'b00};
    mem_req.wr_data  = {32'h0, cmd.data} << {addr.mem.word_sel, 5'd0};
  end

  ////////////////////////////////////////
  // Descriptor window
  ////////////////////////////////////////

  // Reads at offsets 0 and 4, writes at 8 and 12
  assign in_window = cmd.valid && addr.io.io && (cmd.address < io_limit);

  always_comb begin
    desc_req.wen     = in_window && cmd.wr && addr.io.wr_win;
    desc_req.ren     = in_window && !cmd.wr && !addr.io.wr_win;
    desc_req.high    = addr.io.high;
    desc_req.mask    = word_mask;
    desc_req.wr_data = cmd.data;
  end

  // Broadcast of writes into the coherent part of data memory
  always_comb begin
    msg.valid = is_write && !addr.mem.io && (cmd.address >= coherent_start);
    msg.addr  = cmd.address[dmem_addr_bits-1:0];
    msg.strb  = word_mask;
    msg.data  = cmd.data;
  end

  // The whole lower half is data memory, so only io_limit can be overrun
  // Inside the window the direction must match the write-window bit
  assign bad_access = cmd.valid &&
                      ((cmd.address >= io_limit) ||
                       (addr.io.io && (cmd.wr != addr.io.wr_win)));

  always_ff @(posedge clk) begin
    if (rst) begin
      rsp_valid <= 1'b0;
      rsp_error <= 1'b0;
    end else begin
      rsp_valid <= cmd.valid;
      rsp_error <= rsp_error || bad_access;
    end
  end

endmodule

// File: source/desc_mailbox.sv
`timescale 1ns/1ps

module desc_mailbox (
  input  logic                                clk,
  input  logic                                rst,
  input  core_shell_pkg::desc_req_t           req,
  input  logic [core_shell_pkg::line_bits-1:0] in_desc,
  input  logic                                in_desc_valid,
  output logic                                in_desc_taken,
  output logic [core_shell_pkg::line_bits-1:0] out_desc,
  output logic                                out_desc_valid,
  input  logic                                out_desc_taken,
  output logic [31:0]                         rd_data,
  output logic                                rd_sel
);
  import core_shell_pkg::*;

  logic [line_bytes-1:0] line_mask;
  logic [line_bits-1:0]  line_data;
  logic                  out_lo_v;
  logic                  out_hi_v;
  logic                  in_lo_rd;
  logic                  in_hi_rd;

  ////////////////////////////////////////
  // Outgoing descriptor
  ////////////////////////////////////////

  assign line_mask = req.high ? {req.mask, 4'h0} : {4'h0, req.mask};
  assign line_data = {req.wr_data, req.wr_data};

  // Held bytes may still be patched while waiting for taken
  always_ff @(posedge clk) begin
    for (int i = 0; i < line_bytes; i++) begin
      if (req.wen && line_mask[i]) begin
        out_desc[i*8 +: 8] <= line_data[i*8 +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_lo_v <= 1'b0;
      out_hi_v <= 1'b0;
    end else if (out_desc_valid && out_desc_taken) begin
      out_lo_v <= 1'b0;
      out_hi_v <= 1'b0;
    end else if (req.wen) begin
      if (req.high) begin
        out_hi_v <= 1'b1;
      end else begin
        out_lo_v <= 1'b1;
      end
    end
  end

  assign out_desc_valid = out_lo_v && out_hi_v;

  ////////////////////////////////////////
  // Incoming descriptor
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (req.ren) begin
      if (!in_desc_valid) begin
        rd_data <= 32'h0;
      end else begin
        rd_data <= req.high ? in_desc[63:32] : in_desc[31:0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      in_lo_rd <= 1'b0;
      in_hi_rd <= 1'b0;
      rd_sel   <= 1'b0;
    end else begin
      rd_sel <= req.ren;
      if (req.ren) begin
        if (!in_desc_valid) begin
          in_lo_rd <= 1'b0;
          in_hi_rd <= 1'b0;
        end else if (req.high) begin
          in_hi_rd <= 1'b1;
        end else begin
          in_lo_rd <= 1'b1;
        end
      end
      // Handshake done, wait for the next descriptor
      if (in_desc_taken && in_desc_valid) begin
        in_lo_rd <= 1'b0;
        in_hi_rd <= 1'b0;
      end
    end
  end

  assign in_desc_taken = in_lo_rd && in_hi_rd;

endmodule

// File: source/fetch_port.sv
`timescale 1ns/1ps

module fetch_port (
  input  logic                         clk,
  input  logic                         rst,
  input  core_shell_pkg::ibus_cmd_t    cmd,
  output core_shell_pkg::ibus_rsp_t    rsp,
  input  core_shell_pkg::ins_dma_req_t dma
);
  import core_shell_pkg::*;

  logic                 word_sel_q;
  logic                 valid_q;
  logic                 error_q;
  logic [line_bits-1:0] inst_line;

  // Written by DMA only, the core just fetches
  line_ram_1r1w #(
    .depth_bits(imem_line_bits)
  ) i_imem (
    .clk  (clk),
    .wea  (dma.wen),
    .addra(dma.addr[imem_addr_bits-1:line_off_bits]),
    .dina (dma.wr_data),
    .enb  (cmd.valid),
    .addrb(cmd.pc[imem_addr_bits-1:line_off_bits]),
    .doutb(inst_line)
  );

  always_ff @(posedge clk) begin
    word_sel_q <= cmd.pc[2];
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
      error_q <= 1'b0;
    end else begin
      valid_q <= cmd.valid;
      error_q <= error_q || (cmd.valid && |cmd.pc[31:imem_addr_bits]);
    end
  end

  always_comb begin
    rsp.valid = valid_q;
    rsp.error = error_q;
    rsp.inst  = word_sel_q ? inst_line[63:32] : inst_line[31:0];
  end

endmodule

// File: source/line_ram_1r1w.sv
`timescale 1ns/1ps

module line_ram_1r1w #(
  parameter int depth_bits = 10
) (
  input  logic                                clk,
  input  logic [core_shell_pkg::line_bytes-1:0] wea,
  input  logic [depth_bits-1:0]               addra,
  input  logic [core_shell_pkg::line_bits-1:0]  dina,
  input  logic                                enb,
  input  logic [depth_bits-1:0]               addrb,
  output logic [core_shell_pkg::line_bits-1:0]  doutb
);
  import core_shell_pkg::*;

  logic [line_bits-1:0] mem [2**depth_bits];

  // Byte lane writes
  always_ff @(posedge clk) begin
    for (int i = 0; i < line_bytes; i++) begin
      if (wea[i]) begin
        mem[addra][i*8 +: 8] <= dina[i*8 +: 8];
      end
    end
  end

  // Registered read, old data on a same-line collision
  always_ff @(posedge clk) begin
    if (enb) begin
      doutb <= mem[addrb];
    end
  end

endmodule

// File: source/line_ram_2rw.sv
`timescale 1ns/1ps

module line_ram_2rw #(
  parameter int depth_bits = 12
) (
  input  logic                                clk,
  input  logic                                ena,
  input  logic                                rena,
  input  logic [core_shell_pkg::line_bytes-1:0] wena,
  input  logic [depth_bits-1:0]               addra,
  input  logic [core_shell_pkg::line_bits-1:0]  dina,
  output logic [core_shell_pkg::line_bits-1:0]  douta,
  input  logic                                enb,
  input  logic                                renb,
  input  logic [core_shell_pkg::line_bytes-1:0] wenb,
  input  logic [depth_bits-1:0]               addrb,
  input  logic [core_shell_pkg::line_bits-1:0]  dinb,
  output logic [core_shell_pkg::line_bits-1:0]  doutb
);
  import core_shell_pkg::*;

  logic [line_bits-1:0] mem [2**depth_bits];

  // Both ports share one process so the array has a single driver
  // Same-line writes from both sides in one cycle give an undefined line
  always_ff @(posedge clk) begin
    if (ena) begin
      for (int i = 0; i < line_bytes; i++) begin
        if (wena[i]) begin
          mem[addra][i*8 +: 8] <= dina[i*8 +: 8];
        end
      end
      if (rena) begin
        douta <= mem[addra];
      end
    end
    if (enb) begin
      for (int i = 0; i < line_bytes; i++) begin
        if (wenb[i]) begin
          mem[addrb][i*8 +: 8] <= dinb[i*8 +: 8];
        end
      end
      if (renb) begin
        doutb <= mem[addrb];
      end
    end
  end

endmodule
